/* Makefile */
VERILATOR  ?= verilator
TOP        ?= eeprom_tb
RTL_TOP    ?= eeprom_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
RTL_FILES  ?= $(filter hdl/%,$(shell cat $(FILELIST)))
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/byte_shifter.sv */
module byte_shifter
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       reset,
    input  bus_event_t bus_ev,
    input  logic       ack_en,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    output logic [7:0] rx_byte,
    output logic       byte_done,
    output logic       sda_oe
);

    logic [3:0] bit_cnt;
    logic       ack_slot;
    logic       tx_mode;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    assign rx_byte = rx_shift;

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            bit_cnt   <= '0;
            ack_slot  <= 1'b0;
            tx_mode   <= 1'b0;
            sda_oe    <= 1'b0;
            byte_done <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (bus_ev.start || bus_ev.stop)
            begin
                bit_cnt  <= '0;
                ack_slot <= 1'b0;
                tx_mode  <= 1'b0;
                sda_oe   <= 1'b0;
            end
            else if (bus_ev.bit_sample)
            begin
                // ninth sample is the acknowledge, not counted
                if (bit_cnt < 4'd8)
                begin
                    bit_cnt   <= bit_cnt + 4'd1;
                    byte_done <= !tx_mode && (bit_cnt == 4'd7);
                end
            end
            else if (bus_ev.clk_fall)
            begin
                if (ack_slot)
                begin
                    // end of the ninth slot, a read byte may start here
                    ack_slot <= 1'b0;
                    bit_cnt  <= '0;
                    tx_mode  <= tx_load;
                    sda_oe   <= tx_load && !tx_byte[7];
                end
                else if (bit_cnt == 4'd8)
                begin
                    // master owns the line after a read byte
                    ack_slot <= 1'b1;
                    sda_oe   <= !tx_mode && ack_en;
                end
                else if (tx_mode)
                begin
                    sda_oe <= !tx_shift[6];
                end
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (tx_load)
            tx_shift <= tx_byte;
        else if (bus_ev.clk_fall && tx_mode && bit_cnt < 4'd8)
            tx_shift <= tx_shift << 1;
        if (bus_ev.bit_sample && !tx_mode && bit_cnt < 4'd8)
            rx_shift <= {rx_shift[6:0], bus_ev.bit_value};
    end

endmodule

/* hdl/eeprom_control.sv */
module eeprom_control
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       reset,
    input  bus_event_t bus_ev,
    input  logic       byte_done,
    input  logic [7:0] rx_byte,
    input  logic [7:0] mem_rdata,
    output logic       ack_en,
    output logic       tx_load,
    output logic       mem_we,
    output logic       mem_re,
    output addr_t      mem_addr,
    output logic [7:0] mem_wdata,
    output logic [7:0] tx_byte
);

    ctrl_state_t state;
    ctrl_byte_t  rx_ctrl;
    logic [2:0]  block_q;
    logic [7:0]  addr_q;
    logic [7:0]  wdata_q;
    logic        fall_seen;
    logic        ack_end;
    logic        code_ok;

    assign rx_ctrl = ctrl_byte_t'(rx_byte);
    assign code_ok = (rx_ctrl.device == device_code);

    // second clock fall after byte_done closes the acknowledge slot
    assign ack_end = bus_ev.clk_fall && ack_en && fall_seen;
    assign tx_load = ack_end && (state == send_data);

    assign mem_addr  = {block_q, addr_q};
    assign mem_wdata = wdata_q;
    assign tx_byte   = mem_rdata;

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            state     <= idle;
            ack_en    <= 1'b0;
            fall_seen <= 1'b0;
            mem_we    <= 1'b0;
            mem_re    <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            if (bus_ev.stop)
            begin
                state     <= idle;
                ack_en    <= 1'b0;
                fall_seen <= 1'b0;
            end
            else if (bus_ev.start)
            begin
                ack_en    <= 1'b0;
                fall_seen <= 1'b0;
                case (state)
                    wait_restart: state <= get_rctrl;
                    ignore:       state <= ignore;
                    default:      state <= get_ctrl;
                endcase
            end
            else if (byte_done)
            begin
                case (state)
                    get_ctrl:
                    begin
                        // current-address reads are not supported
                        if (code_ok && !rx_ctrl.rw)
                        begin
                            state  <= get_addr;
                            ack_en <= 1'b1;
                        end
                        else
                            state <= ignore;
                    end
                    get_addr:
                    begin
                        state  <= wait_restart;
                        ack_en <= 1'b1;
                    end
                    wait_restart:
                    begin
                        // a data byte instead of a restart, so write it
                        state  <= get_data;
                        ack_en <= 1'b1;
                        mem_we <= 1'b1;
                    end
                    get_rctrl:
                    begin
                        if (code_ok && rx_ctrl.rw)
                        begin
                            state  <= send_data;
                            ack_en <= 1'b1;
                            mem_re <= 1'b1;
                        end
                        else
                            state <= ignore;
                    end
                    default:
                    begin
                    end
                endcase
            end
            else if (bus_ev.clk_fall && ack_en)
            begin
                if (fall_seen)
                begin
                    ack_en    <= 1'b0;
                    fall_seen <= 1'b0;
                    if (state == get_data)
                        state <= idle;
                end
                else
                    fall_seen <= 1'b1;
            end
        end
    end

    // address and data bytes as they arrive
    always_ff @(posedge scl)
    begin
        if (byte_done)
        begin
            case (state)
                get_ctrl,
                get_rctrl:    block_q <= rx_ctrl.block;
                get_addr:     addr_q  <= rx_byte;
                wait_restart: wdata_q <= rx_byte;
                default:
                begin
                end
            endcase
        end
    end

endmodule

/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    // number of stored bytes
    localparam int mem_depth = 2048;

    // block bits in the top three, address byte below
    typedef logic [$clog2(mem_depth)-1:0] addr_t;

    // every valid control byte carries this in its upper nibble
    localparam logic [3:0] device_code = 4'b1010;

    // overlays a received control byte
    typedef struct packed {
        logic [3:0] device;
        logic [2:0] block;
        logic       rw;     // 1 means read
    } ctrl_byte_t;

    // one-cycle strobes of scl, bit_value is valid with bit_sample
    typedef struct packed {
        logic start;
        logic stop;
        logic bit_sample;
        logic bit_value;
        logic clk_fall;
    } bus_event_t;

    // transaction states of the controller
    typedef enum logic [2:0] {
        idle,
        get_ctrl,
        get_addr,
        get_data,
        wait_restart,
        get_rctrl,
        send_data,
        ignore
    } ctrl_state_t;

endpackage

/* hdl/eeprom_top.sv */
module eeprom_top
    import eeprom_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  logic scl,
    input  logic reset,
    input  logic bus_clk,
    input  logic sda_in,
    output logic sda_oe
);

    bus_event_t bus_ev;
    logic [7:0] rx_byte;
    logic       byte_done;
    logic       ack_en;
    logic       tx_load;
    logic [7:0] tx_byte;
    logic       mem_we;
    logic       mem_re;
    addr_t      mem_addr;
    logic [7:0] mem_wdata;
    logic [7:0] mem_rdata;

    line_sampler #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_sampler (
        .scl    (scl),
        .reset  (reset),
        .bus_clk(bus_clk),
        .sda_in (sda_in),
        .bus_ev (bus_ev)
    );

    byte_shifter u_shifter (
        .scl      (scl),
        .reset    (reset),
        .bus_ev   (bus_ev),
        .ack_en   (ack_en),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .rx_byte  (rx_byte),
        .byte_done(byte_done),
        .sda_oe   (sda_oe)
    );

    eeprom_control u_control (
        .scl      (scl),
        .reset    (reset),
        .bus_ev   (bus_ev),
        .byte_done(byte_done),
        .rx_byte  (rx_byte),
        .mem_rdata(mem_rdata),
        .ack_en   (ack_en),
        .tx_load  (tx_load),
        .mem_we   (mem_we),
        .mem_re   (mem_re),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .tx_byte  (tx_byte)
    );

    memory_array u_memory (
        .scl      (scl),
        .mem_we   (mem_we),
        .mem_re   (mem_re),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

endmodule

/* hdl/line_sampler.sv */
module line_sampler
    import eeprom_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  logic       scl,
    input  logic       reset,
    input  logic       bus_clk,
    input  logic       sda_in,
    output bus_event_t bus_ev
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   clk_old;
    logic                   sda_old;
    logic                   clk_now;
    logic                   sda_now;

    assign clk_now = clk_sync[SYNC_STAGES-1];
    assign sda_now = sda_sync[SYNC_STAGES-1];

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            // idle bus has both lines high
            clk_sync <= '1;
            sda_sync <= '1;
            clk_old  <= 1'b1;
            sda_old  <= 1'b1;
            bus_ev   <= '0;
        end
        else
        begin
            clk_sync <= (clk_sync << 1) | SYNC_STAGES'(bus_clk);
            sda_sync <= (sda_sync << 1) | SYNC_STAGES'(sda_in);
            clk_old  <= clk_now;
            sda_old  <= sda_now;

            // data edges with the clock high are framing, not data
            bus_ev.start      <= clk_old && clk_now && sda_old && !sda_now;
            bus_ev.stop       <= clk_old && clk_now && !sda_old && sda_now;
            bus_ev.bit_sample <= !clk_old && clk_now;
            bus_ev.bit_value  <= sda_now;
            bus_ev.clk_fall   <= clk_old && !clk_now;
        end
    end

endmodule

/* hdl/memory_array.sv */
module memory_array
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       mem_we,
    input  logic       mem_re,
    input  addr_t      mem_addr,
    input  logic [7:0] mem_wdata,
    output logic [7:0] mem_rdata
);

    logic [7:0] mem [mem_depth];

    // device comes up erased to zero
    initial
    begin
        for (int i = 0; i < mem_depth; i++)
            mem[i] = 8'h00;
    end

    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        if (mem_re)
            mem_rdata <= mem[mem_addr];
    end

endmodule

/* sim/eeprom_assertions.sv */
module eeprom_assertions
    import eeprom_pkg::*;
(
    input logic        scl,
    input logic        reset,
    input logic        sda_oe,
    input logic        clk_sync,
    input bus_event_t  bus_ev,
    input logic        mem_we,
    input ctrl_state_t state
);

    int          failures = 0;
    int unsigned samples;

    // bit samples since the last start or stop
    always_ff @(posedge scl)
    begin
        if (reset || bus_ev.start || bus_ev.stop)
            samples <= 0;
        else if (bus_ev.bit_sample)
            samples <= samples + 1;
    end

    reset_quiet: assert property (@(posedge scl) reset |=> !sda_oe)
    else
    begin
        $error("sda_oe driven while reset is high");
        failures++;
    end

    // the line is free right after a start or stop
    framing_quiet: assert property (@(posedge scl) disable iff (reset)
        (bus_ev.start || bus_ev.stop) |=> !sda_oe)
    else
    begin
        $error("sda_oe driven in the cycle after a start or stop");
        failures++;
    end

    oe_stable: assert property (@(posedge scl) disable iff (reset)
        (clk_sync && $past(clk_sync)) |-> $stable(sda_oe))
    else
    begin
        $error("sda_oe changed while bus clock is high");
        failures++;
    end

    // a write follows the third byte of a frame, 26 bit samples after its start
    write_state: assert property (@(posedge scl) disable iff (reset)
        mem_we |-> state == get_data && samples == 26)
    else
    begin
        $error("memory write outside the data byte of a write frame");
        failures++;
    end

    stop_idle: assert property (@(posedge scl) disable iff (reset)
        bus_ev.stop |=> state == idle)
    else
    begin
        $error("controller not idle after stop");
        failures++;
    end

endmodule

/* sim/eeprom_tb.sv */
module eeprom_tb
    import eeprom_pkg::*;
();

    localparam int half = 10;
    localparam int ack_timeout = 200;

    logic       scl = 1'b0;
    logic       reset;
    logic       bus_clk;
    logic       sda_in;
    logic       sda_oe;
    logic       sda_line;
    logic [7:0] shadow [mem_depth];
    int         oe_count = 0;
    int         errors = 0;
    int         seen = 0;
    int         passed = 0;
    int         failed = 0;

    // open-drain bus as the master sees it
    assign sda_line = sda_in & ~sda_oe;

    eeprom_top #(
        .SYNC_STAGES(2)
    ) uut (
        .scl    (scl),
        .reset  (reset),
        .bus_clk(bus_clk),
        .sda_in (sda_in),
        .sda_oe (sda_oe)
    );

    bind eeprom_top eeprom_assertions protocol_checks (
        .scl     (scl),
        .reset   (reset),
        .sda_oe  (sda_oe),
        .clk_sync(u_sampler.clk_now),
        .bus_ev  (bus_ev),
        .mem_we  (mem_we),
        .state   (u_control.state)
    );

    always #50 scl = ~scl;

    always @(posedge scl)
    begin
        if (sda_oe)
            oe_count++;
    end

    task automatic hold(input int n);
        repeat (n) @(posedge scl);
    endtask

    task automatic start_condition();
        sda_in <= 1'b1;
        hold(half);
        bus_clk <= 1'b1;
        hold(half);
        sda_in <= 1'b0;
        hold(half);
        bus_clk <= 1'b0;
        hold(2);
    endtask

    // expects bus_clk low on entry
    task automatic stop_condition();
        sda_in <= 1'b0;
        hold(half);
        bus_clk <= 1'b1;
        hold(half);
        sda_in <= 1'b1;
        hold(half);
    endtask

    task automatic send_bit(input logic b);
        sda_in <= b;
        hold(half);
        bus_clk <= 1'b1;
        hold(half);
        bus_clk <= 1'b0;
        hold(2);
    endtask

    task automatic sample_bit(output logic b);
        sda_in <= 1'b1;
        hold(half);
        bus_clk <= 1'b1;
        hold(half);
        b = sda_line;
        bus_clk <= 1'b0;
        hold(2);
    endtask

    task automatic await_ack(output logic acked);
        int waited;
        sda_in <= 1'b1;
        acked = 1'b0;
        waited = 0;
        while (!acked && waited < ack_timeout)
        begin
            @(posedge scl);
            waited++;
            acked = !sda_line;
        end
        if (waited < half)
            hold(half - waited);
        bus_clk <= 1'b1;
        hold(half);
        bus_clk <= 1'b0;
        hold(2);
    endtask

    task automatic send_byte(input logic [7:0] data, output logic acked);
        for (int i = 7; i >= 0; i--)
            send_bit(data[i]);
        await_ack(acked);
    endtask

    // single byte read closed by a not-acknowledge
    task automatic receive_byte(output logic [7:0] data);
        logic b;
        data = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            sample_bit(b);
            data = {data[6:0], b};
        end
        send_bit(1'b1);
    endtask

    task automatic check_write(input addr_t addr, input logic [7:0] data);
        logic a0;
        logic a1;
        logic a2;
        start_condition();
        send_byte({4'b1010, addr[10:8], 1'b0}, a0);
        send_byte(addr[7:0], a1);
        send_byte(data, a2);
        stop_condition();
        if (a0 && a1 && a2)
            shadow[addr] = data;
        else
        begin
            $display("no acknowledge while writing address %03h", addr);
            errors++;
        end
    endtask

    task automatic check_read(input addr_t addr);
        logic       a0;
        logic       a1;
        logic       a2;
        logic [7:0] data;
        start_condition();
        send_byte({4'b1010, addr[10:8], 1'b0}, a0);
        send_byte(addr[7:0], a1);
        start_condition();
        send_byte({4'b1010, addr[10:8], 1'b1}, a2);
        receive_byte(data);
        stop_condition();
        if (!(a0 && a1 && a2))
        begin
            $display("no acknowledge while reading address %03h", addr);
            errors++;
        end
        else if (data !== shadow[addr])
        begin
            $display("** Error tx_byte[%03h] expected %02h, got %02h", addr, shadow[addr], data);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + uut.protocol_checks.failures;
        if (total == seen)
        begin
            passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            failed++;
            $display("test %s: FAILED", name);
        end
        seen = total;
    endtask

    initial
    begin
        logic [31:0] rnd;
        addr_t       addr;
        logic        a0;
        logic        a1;
        logic        a2;
        int          mark;
        reset = 1'b1;
        bus_clk = 1'b1;
        sda_in = 1'b1;
        void'($urandom(32'hdd439077));
        for (int i = 0; i < mem_depth; i++)
            shadow[i] = 8'h00;
        hold(5);
        reset <= 1'b0;
        hold(2);

        mark = oe_count;
        hold(20);
        if (oe_count != mark)
        begin
            $display("** Error sda_oe expected 0, got 1 on an idle bus");
            errors++;
        end
        rnd = $urandom();
        check_read(rnd[10:0]);
        end_test("reset state");

        rnd = $urandom();
        check_write(rnd[10:0], rnd[18:11]);
        check_read(rnd[10:0]);
        end_test("write then read");

        // same address byte under opposite block bits
        rnd = $urandom();
        addr = rnd[10:0];
        check_write(addr, rnd[18:11]);
        check_write({~addr[10:8], addr[7:0]}, ~rnd[18:11]);
        check_read(addr);
        check_read({~addr[10:8], addr[7:0]});
        end_test("block bits");

        rnd = $urandom();
        mark = oe_count;
        start_condition();
        send_byte({4'b1001, rnd[10:8], 1'b0}, a0);
        send_byte(rnd[7:0], a1);
        send_byte(~shadow[rnd[10:0]], a2);
        stop_condition();
        if (a0 || a1 || a2 || oe_count != mark)
        begin
            $display("device answered a control byte with a wrong device code");
            errors++;
        end
        check_read(rnd[10:0]);
        end_test("wrong device code");

        // stop after half of the address byte
        rnd = $urandom();
        start_condition();
        send_byte({4'b1010, rnd[10:8], 1'b0}, a0);
        for (int i = 7; i >= 4; i--)
            send_bit(rnd[i]);
        stop_condition();
        if (!a0)
        begin
            $display("no acknowledge for the control byte before the abort");
            errors++;
        end
        rnd = $urandom();
        check_write(rnd[10:0], rnd[18:11]);
        check_read(rnd[10:0]);
        end_test("stop in the middle");

        for (int n = 0; n < 12; n++)
        begin
            rnd = $urandom();
            check_write(rnd[10:0], rnd[18:11]);
            if (n % 2 == 0)
                check_read(rnd[10:0]);
            else
                check_read(rnd[29:19]);
        end
        end_test("random sequence");

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passed, failed, uut.protocol_checks.failures);
        if (failed == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* src.f */
hdl/eeprom_pkg.sv
hdl/line_sampler.sv
hdl/byte_shifter.sv
hdl/eeprom_control.sv
hdl/memory_array.sv
hdl/eeprom_top.sv
sim/eeprom_assertions.sv
sim/eeprom_tb.sv
